/* testbench/atm_stim.txt */
// in_valid in_data  exp_disp exp_valid exp_data  check
// check: 0 none, 1 outputs after the clock edge, 2 outputs in the same cycle
0 00000000  0 0 00000000 1
// card, language echo, wrong pin
1 0000abcd  0 0 00000000 0
0 00000000  1 0 00000000 1
1 00000001  1 1 00000001 2
0 00000000  2 0 00000000 1
1 000004d2  6 0 00000000 1
0 00000000  5 0 00000000 1
0 00000000  0 0 00000000 1
// pin 2000, deposit 25 with confirm, inquiry without receipt
1 00000001  0 0 00000000 0
1 00000000  1 1 00000000 2
1 000007d0  3 0 00000000 1
1 00000002  8 0 00000000 1
1 00000019  9 1 00000019 1
1 00000001 11 1 0000004b 1
0 00000000  4 0 00000000 1
1 00000001  3 0 00000000 1
1 00000003 12 1 0000004b 1
0 00000000 17 0 00000000 1
1 00000000  4 0 00000000 1
1 00000001  3 0 00000000 1
// deposit 40, cash returned, then enter cash times out
1 00000002  8 0 00000000 1
1 00000028  9 1 00000028 1
1 00000000 10 1 00000028 1
0 00000000 10 1 00000028 1
0 00000000 10 1 00000028 1
0 00000000 10 1 00000028 1
0 00000000 10 1 00000028 1
0 00000000 10 1 00000028 1
0 00000000 10 1 00000028 1
0 00000000 10 1 00000028 1
0 00000000 10 1 00000028 1
0 00000000  8 0 00000000 1
0 00000000  8 0 00000000 1
0 00000000  8 0 00000000 1
0 00000000  8 0 00000000 1
0 00000000  8 0 00000000 1
0 00000000  8 0 00000000 1
0 00000000  8 0 00000000 1
0 00000000  8 0 00000000 1
0 00000000  8 0 00000000 1
0 00000000  4 0 00000000 1
1 00000001  3 0 00000000 1
1 00000003 12 1 0000004b 1
0 00000000 17 0 00000000 1
1 00000000  4 0 00000000 1
1 00000001  3 0 00000000 1
// pin change to 4321, one mismatched re-entry first
1 00000004  2 0 00000000 1
1 000010e1 23 0 00000000 1
1 00000457  6 0 00000000 1
0 00000000  2 0 00000000 1
1 000010e1 23 0 00000000 1
1 000010e1 13 0 00000000 1
0 00000000 13 0 00000000 1
0 00000000 13 0 00000000 1
0 00000000 13 0 00000000 1
0 00000000 13 0 00000000 1
0 00000000 13 0 00000000 1
0 00000000 13 0 00000000 1
0 00000000 13 0 00000000 1
0 00000000 13 0 00000000 1
0 00000000 24 0 00000000 1
0 00000000  4 0 00000000 1
1 00000000  5 0 00000000 1
0 00000000  0 0 00000000 1
// old pin refused
1 00000001  0 0 00000000 0
1 00000000  1 1 00000000 2
0 00000000  2 0 00000000 1
1 000007d0  6 0 00000000 1
0 00000000  5 0 00000000 1
0 00000000  0 0 00000000 1
// new pin, unknown code, inquiry with receipt
1 00000001  0 0 00000000 0
1 00000001  1 1 00000001 2
1 000010e1  3 0 00000000 1
1 00000005  3 0 00000000 1
1 00000003 12 1 0000004b 1
0 00000000 17 0 00000000 1
1 00000001 13 1 0000004b 1
0 00000000 13 1 0000004b 1
0 00000000 13 1 0000004b 1
0 00000000 13 1 0000004b 1
0 00000000 13 1 0000004b 1
0 00000000 13 1 0000004b 1
0 00000000 13 1 0000004b 1
0 00000000 13 1 0000004b 1
0 00000000 13 1 0000004b 1
0 00000000  4 0 00000000 1
1 00000000  5 0 00000000 1
0 00000000  0 0 00000000 1

/* verilog.f */
+incdir+include
hdl/atm_pkg.sv
hdl/session_ctrl.sv
hdl/deposit_service.sv
hdl/inquiry_service.sv
hdl/pin_change_service.sv
hdl/account_store.sv
hdl/service_select.sv
hdl/atm_top.sv
testbench/tb_atm.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build tb_atm with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_atm -f verilog.f
	@out="$$(./obj_dir/Vtb_atm)"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

/* testbench/tb_atm.sv */
`timescale 1ns/1ps
`include "atm_settings.svh"

module tb_atm;

    // one cycle of stimulus and its expected response
    typedef struct packed {
        logic                   in_valid;
        logic [`ATM_IN_W-1:0]   in_data;
        logic [`ATM_DISP_W-1:0] disp;
        logic                   valid;
        logic [`ATM_OUT_W-1:0]  data;
        logic [1:0]             check;
    } stim_line_t;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    logic [`ATM_IN_W-1:0]   in_data;
    logic [`ATM_DISP_W-1:0] disp_sig;
    logic                   data_valid;
    logic [`ATM_OUT_W-1:0]  out_data;

    stim_line_t stim[$];
    logic       stim_loaded;
    int         error_count;
    int         check_count;
    int         step;

    atm_top i_dut (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_data(in_data),
        .disp_sig(disp_sig),
        .data_valid(data_valid),
        .out_data(out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        begin
            check_count++;
            if (got !== exp)
            begin
                error_count++;
                $display("Mismatch at %0t ns: step %0d %s is %0h, expected %0h",
                         $time, step, what, got, exp);
            end
        end
    endtask

    task automatic compare_outputs(input stim_line_t exp_line, input int idx);
        begin
            step = idx + 1;   // steps counted from 1
            check_value("disp_sig", 32'(disp_sig), 32'(exp_line.disp));
            check_value("data_valid", 32'(data_valid), 32'(exp_line.valid));
            check_value("out_data", 32'(out_data), 32'(exp_line.data));
        end
    endtask

    task automatic load_stimulus(output logic ok);
        int                  fd;
        int                  n;
        int                  skip;
        int                  exp_disp;
        int                  flag;
        logic                v;
        logic [31:0]         d;
        logic                exp_valid;
        logic [31:0]         exp_data;
        logic [8*200-1:0]    rest;
        logic                at_end;
        logic                bad;
        stim_line_t          entry;
        begin
            ok     = 1'b0;
            at_end = 1'b0;
            bad    = 1'b0;
            fd = $fopen("testbench/atm_stim.txt", "r");
            if (fd == 0)
            begin
                $display("Could not open testbench/atm_stim.txt for reading");
                bad = 1'b1;
            end
            else
            begin
                while (!at_end)
                begin
                    n = $fscanf(fd, "%h %h %d %h %h %d\n",
                                v, d, exp_disp, exp_valid, exp_data, flag);
                    if (n == 6)
                    begin
                        entry.in_valid = v;
                        entry.in_data  = d;
                        entry.disp     = `ATM_DISP_W'(exp_disp);
                        entry.valid    = exp_valid;
                        entry.data     = exp_data;
                        entry.check    = 2'(flag);
                        stim.push_back(entry);
                    end
                    else if (n < 0)
                        at_end = 1'b1;
                    else if (n == 0)
                    begin
                        skip = $fgets(rest, fd);   // comment line
                        if (skip == 0)
                            at_end = 1'b1;
                    end
                    else
                    begin
                        $display("Stimulus file has a broken line after step %0d",
                                 stim.size());
                        bad    = 1'b1;
                        at_end = 1'b1;
                    end
                end
                $fclose(fd);
                if (stim.size() == 0)
                    $display("Stimulus file holds no stimulus lines");
            end
            ok = !bad && (stim.size() > 0);
        end
    endtask

    // expected values of a line are compared at the next falling edge,
    // or one ns after driving when the line checks the same cycle
    task automatic run_stimulus();
        stim_line_t cur;
        stim_line_t prev;
        begin
            prev = '0;
            for (int i = 0; i <= stim.size(); i++)
            begin
                @(negedge clk);
                if (prev.check == 2'd1)
                    compare_outputs(prev, i - 1);
                if (i < stim.size())
                begin
                    cur      = stim[i];
                    in_valid = cur.in_valid;
                    in_data  = cur.in_data;
                    if (cur.check == 2'd2)
                    begin
                        #1;   // still ahead of the rising edge
                        compare_outputs(cur, i);
                    end
                    prev = cur;
                end
            end
            in_valid = 1'b0;
            in_data  = '0;
        end
    endtask

    task automatic print_summary();
        begin
            $display("Checks run: %0d, errors: %0d", check_count, error_count);
        end
    endtask

    initial
    begin
        logic ok;
        rst         = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        error_count = 0;
        check_count = 0;
        step        = 0;
        stim_loaded = 1'b0;
        load_stimulus(ok);
        stim_loaded = 1'b1;
        if (!ok)
        begin
            $display("No usable stimulus, the run stops before reset");
            print_summary();
            $display("TESTS FAILED");
        end
        else
        begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst = 1'b1;
            run_stimulus();
            print_summary();
            if (error_count == 0)
                $display("TESTS PASSED");
            else
                $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized from the stimulus length
    initial
    begin
        wait (stim_loaded);
        #((stim.size() + 20) * CLK_PERIOD);
        $display("Watchdog expired before the stimulus was finished");
        print_summary();
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* hdl/atm_top.sv */
`timescale 1ns/1ps
`include "atm_settings.svh"

module atm_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  logic [`ATM_IN_W-1:0]   in_data,
    output logic [`ATM_DISP_W-1:0] disp_sig,
    output logic                   data_valid,
    output logic [`ATM_OUT_W-1:0]  out_data
);
    import atm_pkg::*;

    atm_entry_u            entry;
    service_e              svc_code;
    service_e              active_svc;
    svc_out_t              session_out;
    svc_out_t              dep_out;
    svc_out_t              inq_out;
    svc_out_t              pin_out;
    logic                  svc_start;
    logic                  svc_done;
    logic                  dep_done;
    logic                  inq_done;
    logic                  pin_done;
    logic                  dep_timer_req;
    logic                  inq_timer_req;
    logic                  pin_timer_req;
    logic                  timer_done;
    logic                  bal_we;
    logic                  pin_we;
    logic [`ATM_BAL_W-1:0] bal_wdata;
    logic [`ATM_BAL_W-1:0] balance;
    logic [`ATM_PIN_W-1:0] pin_wdata;
    logic [`ATM_PIN_W-1:0] stored_pin;

    assign entry    = in_data;
    assign svc_done = dep_done | inq_done | pin_done;

    session_ctrl i_session (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_data(entry),
        .stored_pin(stored_pin), .svc_done(svc_done), .svc_start(svc_start),
        .svc_code(svc_code), .active_svc(active_svc), .session_out(session_out)
    );

    deposit_service i_deposit (
        .clk(clk), .rst(rst), .svc_start(svc_start && svc_code == SVC_DEPOSIT),
        .in_valid(in_valid), .in_data(entry), .balance(balance), .timer_done(timer_done),
        .timer_req(dep_timer_req), .bal_we(bal_we), .bal_wdata(bal_wdata),
        .done(dep_done), .dep_out(dep_out)
    );

    inquiry_service i_inquiry (
        .clk(clk), .rst(rst), .svc_start(svc_start && svc_code == SVC_INQUIRY),
        .in_valid(in_valid), .in_data(entry), .balance(balance), .timer_done(timer_done),
        .timer_req(inq_timer_req), .done(inq_done), .inq_out(inq_out)
    );

    pin_change_service i_pin_change (
        .clk(clk), .rst(rst), .svc_start(svc_start && svc_code == SVC_PIN),
        .in_valid(in_valid), .in_data(entry), .timer_done(timer_done),
        .timer_req(pin_timer_req), .pin_we(pin_we), .pin_wdata(pin_wdata),
        .done(pin_done), .pin_out(pin_out)
    );

    account_store i_store (
        .clk(clk), .rst(rst), .bal_we(bal_we), .bal_wdata(bal_wdata), .pin_we(pin_we),
        .pin_wdata(pin_wdata), .balance(balance), .stored_pin(stored_pin)
    );

    service_select i_select (
        .clk(clk), .rst(rst), .active_svc(active_svc), .session_out(session_out),
        .dep_out(dep_out), .inq_out(inq_out), .pin_out(pin_out),
        .dep_timer_req(dep_timer_req), .inq_timer_req(inq_timer_req),
        .pin_timer_req(pin_timer_req), .timer_done(timer_done), .disp_sig(disp_sig),
        .data_valid(data_valid), .out_data(out_data)
    );

endmodule

/* hdl/service_select.sv */
`timescale 1ns/1ps
`include "atm_settings.svh"

module service_select (
    input  logic                   clk,
    input  logic                   rst,
    input  atm_pkg::service_e      active_svc,
    input  atm_pkg::svc_out_t      session_out,
    input  atm_pkg::svc_out_t      dep_out,
    input  atm_pkg::svc_out_t      inq_out,
    input  atm_pkg::svc_out_t      pin_out,
    input  logic                   dep_timer_req,
    input  logic                   inq_timer_req,
    input  logic                   pin_timer_req,
    output logic                   timer_done,
    output logic [`ATM_DISP_W-1:0] disp_sig,
    output logic                   data_valid,
    output logic [`ATM_OUT_W-1:0]  out_data
);
    import atm_pkg::*;

    localparam int CNT_W = $clog2(`ATM_DWELL + 1);

    svc_out_t   bus;
    logic       active_req;
    logic [CNT_W-1:0] count;

    always_comb
    begin
        bus        = session_out;
        active_req = 1'b0;
        case (active_svc)
            SVC_DEPOSIT:
            begin
                bus        = dep_out;
                active_req = dep_timer_req;
            end
            SVC_INQUIRY:
            begin
                bus        = inq_out;
                active_req = inq_timer_req;
            end
            SVC_PIN:
            begin
                bus        = pin_out;
                active_req = pin_timer_req;
            end
            default:
                bus = session_out;
        endcase
    end

    assign disp_sig   = bus.disp;
    assign data_valid = bus.valid;
    assign out_data   = bus.data;

    // dwell counter restarts after each expiry so back to back timed states work
    assign timer_done = active_req && (count == CNT_W'(`ATM_DWELL));

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            count <= '0;
        else if (!active_req || timer_done)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    assert property (@(posedge clk) disable iff (!rst)
        timer_done |-> $past(active_req, `ATM_DWELL));

endmodule

/* hdl/account_store.sv */
`timescale 1ns/1ps
`include "atm_settings.svh"

module account_store (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bal_we,
    input  logic [`ATM_BAL_W-1:0] bal_wdata,
    input  logic                  pin_we,
    input  logic [`ATM_PIN_W-1:0] pin_wdata,
    output logic [`ATM_BAL_W-1:0] balance,
    output logic [`ATM_PIN_W-1:0] stored_pin
);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            balance    <= `ATM_BAL_W'(`ATM_INIT_BAL);
            stored_pin <= `ATM_PIN_W'(`ATM_INIT_PIN);
        end
        else
        begin
            if (bal_we)
                balance <= bal_wdata;
            if (pin_we)
                stored_pin <= pin_wdata;   // new pin counts from the next card
        end
    end

    // deposit and pin change never run in the same session step
    assert property (@(posedge clk) disable iff (!rst) !(bal_we && pin_we));

endmodule

/* hdl/pin_change_service.sv */
`timescale 1ns/1ps
`include "atm_settings.svh"

module pin_change_service (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  svc_start,
    input  logic                  in_valid,
    input  atm_pkg::atm_entry_u   in_data,
    input  logic                  timer_done,
    output logic                  timer_req,
    output logic                  pin_we,
    output logic [`ATM_PIN_W-1:0] pin_wdata,
    output logic                  done,
    output atm_pkg::svc_out_t     pin_out
);
    import atm_pkg::*;

    typedef enum logic [2:0] {
        P_IDLE,
        P_ENTER,
        P_REENTER,
        P_PROC,
        P_BAD,
        P_DONE
    } state_e;

    state_e                state;
    state_e                next_state;
    logic [`ATM_PIN_W-1:0] new_pin;

    assign pin_wdata = new_pin;
    assign pin_we    = (state == P_PROC) && timer_done;   // commit on leaving processing

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= P_IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (state == P_ENTER && in_valid)
            new_pin <= in_data.pin_view.pin;
    end

    always_comb
    begin
        next_state    = state;
        timer_req     = 1'b0;
        done          = 1'b0;
        pin_out.disp  = MSG_ENTRY;
        pin_out.valid = 1'b0;
        pin_out.data  = '0;
        case (state)
            P_IDLE:
            begin
                if (svc_start)
                    next_state = P_ENTER;
            end
            P_ENTER:
            begin
                pin_out.disp = MSG_ENTER_PIN;
                if (in_valid)
                    next_state = P_REENTER;
            end
            P_REENTER:
            begin
                pin_out.disp = MSG_RE_ENTER_PIN;
                if (in_valid)
                    next_state = (in_data.pin_view.pin == new_pin) ? P_PROC : P_BAD;
            end
            P_PROC:
            begin
                pin_out.disp = MSG_TRANS_PROCESSED;
                timer_req    = 1'b1;
                if (timer_done)
                    next_state = P_DONE;
            end
            P_BAD:
            begin
                pin_out.disp = MSG_INVALID_PIN;
                next_state   = P_ENTER;   // start over
            end
            P_DONE:
            begin
                pin_out.disp = MSG_PIN_CHANGED;
                done         = 1'b1;
                next_state   = P_IDLE;
            end
            default:
                next_state = P_IDLE;
        endcase
    end

endmodule

/* hdl/inquiry_service.sv */
`timescale 1ns/1ps
`include "atm_settings.svh"

module inquiry_service (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  svc_start,
    input  logic                  in_valid,
    input  atm_pkg::atm_entry_u   in_data,
    input  logic [`ATM_BAL_W-1:0] balance,
    input  logic                  timer_done,
    output logic                  timer_req,
    output logic                  done,
    output atm_pkg::svc_out_t     inq_out
);
    import atm_pkg::*;

    typedef enum logic [1:0] {
        I_IDLE,
        I_SHOW,
        I_ASK,
        I_RECEIPT
    } state_e;

    state_e state;
    state_e next_state;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= I_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state    = state;
        timer_req     = 1'b0;
        done          = 1'b0;
        inq_out.disp  = MSG_ENTRY;
        inq_out.valid = 1'b0;
        inq_out.data  = '0;
        case (state)
            I_IDLE:
            begin
                if (svc_start)
                    next_state = I_SHOW;
            end
            I_SHOW:
            begin
                inq_out.disp  = MSG_CURRENT_BAL;
                inq_out.valid = 1'b1;
                inq_out.data  = `ATM_OUT_W'(balance);
                next_state    = I_ASK;
            end
            I_ASK:
            begin
                inq_out.disp = MSG_RECEIPT;
                if (in_valid)
                begin
                    done       = ~in_data.menu_view.code[0];   // no receipt wanted
                    next_state = in_data.menu_view.code[0] ? I_RECEIPT : I_IDLE;
                end
            end
            default:
            begin
                inq_out.disp  = MSG_TRANS_PROCESSED;
                inq_out.valid = 1'b1;
                inq_out.data  = `ATM_OUT_W'(balance);
                timer_req     = 1'b1;
                if (timer_done)
                begin
                    done       = 1'b1;
                    next_state = I_IDLE;
                end
            end
        endcase
    end

endmodule

/* hdl/deposit_service.sv */
`timescale 1ns/1ps
`include "atm_settings.svh"

module deposit_service (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  svc_start,
    input  logic                  in_valid,
    input  atm_pkg::atm_entry_u   in_data,
    input  logic [`ATM_BAL_W-1:0] balance,
    input  logic                  timer_done,
    output logic                  timer_req,
    output logic                  bal_we,
    output logic [`ATM_BAL_W-1:0] bal_wdata,
    output logic                  done,
    output atm_pkg::svc_out_t     dep_out
);
    import atm_pkg::*;

    typedef enum logic [2:0] {
        D_IDLE,
        D_ENTER,
        D_CONFIRM,
        D_RETURN,
        D_ACCEPT
    } state_e;

    state_e                 state;
    state_e                 next_state;
    logic [`ATM_CASH_W-1:0] cash;
    logic                   yes;

    assign yes       = in_data.menu_view.code[0];
    assign bal_wdata = balance + `ATM_BAL_W'(cash);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= D_IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (state == D_ENTER && in_valid)
            cash <= in_data[`ATM_CASH_W-1:0];
    end

    always_comb
    begin
        next_state    = state;
        timer_req     = 1'b0;
        bal_we        = 1'b0;
        done          = 1'b0;
        dep_out.disp  = MSG_ENTRY;
        dep_out.valid = 1'b0;
        dep_out.data  = '0;
        case (state)
            D_IDLE:
            begin
                if (svc_start)
                    next_state = D_ENTER;
            end
            D_ENTER:
            begin
                dep_out.disp = MSG_ENTER_CASH;
                timer_req    = 1'b1;
                if (in_valid)
                    next_state = D_CONFIRM;
                else if (timer_done)
                begin
                    done       = 1'b1;   // nothing inserted, give up
                    next_state = D_IDLE;
                end
            end
            D_CONFIRM:
            begin
                dep_out.disp  = MSG_CONFIRM;
                dep_out.valid = 1'b1;
                dep_out.data  = `ATM_OUT_W'(cash);
                if (in_valid)
                begin
                    bal_we     = yes;
                    next_state = yes ? D_ACCEPT : D_RETURN;
                end
            end
            D_RETURN:
            begin
                dep_out.disp  = MSG_TAKE_CASH;
                dep_out.valid = 1'b1;
                dep_out.data  = `ATM_OUT_W'(cash);
                timer_req     = 1'b1;
                if (timer_done)
                    next_state = D_ENTER;
            end
            D_ACCEPT:
            begin
                // store already holds the new balance here
                dep_out.disp  = MSG_DEP_ACCEPTED;
                dep_out.valid = 1'b1;
                dep_out.data  = `ATM_OUT_W'(balance);
                done          = 1'b1;
                next_state    = D_IDLE;
            end
            default:
                next_state = D_IDLE;
        endcase
    end

endmodule

/* hdl/session_ctrl.sv */
`timescale 1ns/1ps
`include "atm_settings.svh"

module session_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  atm_pkg::atm_entry_u   in_data,
    input  logic [`ATM_PIN_W-1:0] stored_pin,
    input  logic                  svc_done,
    output logic                  svc_start,
    output atm_pkg::service_e     svc_code,
    output atm_pkg::service_e     active_svc,
    output atm_pkg::svc_out_t     session_out
);
    import atm_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LANG,
        S_PIN,
        S_MENU,
        S_BUSY,
        S_PROMPT,
        S_BAD_PIN,
        S_EXIT
    } state_e;

    state_e state;
    state_e next_state;
    logic   code_ok;

    assign svc_code  = service_e'(in_data.menu_view.code);
    assign code_ok   = (svc_code == SVC_DEPOSIT) || (svc_code == SVC_INQUIRY) ||
                       (svc_code == SVC_PIN);
    assign svc_start = (state == S_MENU) && in_valid && code_ok;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= S_IDLE;
            active_svc <= SVC_NONE;
        end
        else
        begin
            state <= next_state;
            if (svc_start)
                active_svc <= svc_code;
            else if (svc_done)
                active_svc <= SVC_NONE;
        end
    end

    always_comb
    begin
        next_state        = state;
        session_out.disp  = MSG_ENTRY;
        session_out.valid = 1'b0;
        session_out.data  = '0;
        case (state)
            S_IDLE:
            begin
                if (in_valid)
                    next_state = S_LANG;   // card inserted
            end
            S_LANG:
            begin
                session_out.disp  = MSG_LANG;
                session_out.valid = in_valid;   // echoed in the strobe cycle
                session_out.data  = `ATM_OUT_W'(in_valid & in_data.menu_view.code[0]);
                if (in_valid)
                    next_state = S_PIN;
            end
            S_PIN:
            begin
                session_out.disp = MSG_ENTER_PIN;
                if (in_valid)
                    next_state = (in_data.pin_view.pin == stored_pin) ? S_MENU : S_BAD_PIN;
            end
            S_MENU:
            begin
                session_out.disp = MSG_SELECT_OPTION;
                if (svc_start)
                    next_state = S_BUSY;   // unknown codes stay here
            end
            S_BUSY:
            begin
                session_out.disp = MSG_SELECT_OPTION;
                if (svc_done)
                    next_state = S_PROMPT;
            end
            S_PROMPT:
            begin
                session_out.disp = MSG_ANOTHER;
                if (in_valid)
                    next_state = in_data.menu_view.code[0] ? S_MENU : S_EXIT;
            end
            S_BAD_PIN:
            begin
                session_out.disp = MSG_INVALID_PIN;
                next_state       = S_EXIT;
            end
            default:
            begin
                session_out.disp = MSG_THANK_YOU;
                next_state       = S_IDLE;
            end
        endcase
    end

    // a service only starts when none is running
    assert property (@(posedge clk) disable iff (!rst)
        svc_start |-> (active_svc == SVC_NONE));

endmodule

/* hdl/atm_pkg.sv */
`include "atm_settings.svh"

package atm_pkg;

    // display codes as decoded by the panel
    typedef enum logic [`ATM_DISP_W-1:0] {
        MSG_ENTRY           = 0,
        MSG_LANG            = 1,
        MSG_ENTER_PIN       = 2,
        MSG_SELECT_OPTION   = 3,
        MSG_ANOTHER         = 4,
        MSG_THANK_YOU       = 5,
        MSG_INVALID_PIN     = 6,
        MSG_ENTER_CASH      = 8,
        MSG_CONFIRM         = 9,
        MSG_TAKE_CASH       = 10,
        MSG_DEP_ACCEPTED    = 11,
        MSG_CURRENT_BAL     = 12,
        MSG_TRANS_PROCESSED = 13,
        MSG_RECEIPT         = 17,
        MSG_RE_ENTER_PIN    = 23,
        MSG_PIN_CHANGED     = 24
    } disp_msg_e;

    typedef enum logic [2:0] {
        SVC_NONE    = 0,
        SVC_DEPOSIT = 2,
        SVC_INQUIRY = 3,
        SVC_PIN     = 4
    } service_e;

    // one input word read as a pin or as a menu answer
    typedef union packed {
        struct packed {
            logic [`ATM_IN_W-`ATM_PIN_W-1:0] upper;
            logic [`ATM_PIN_W-1:0]           pin;
        } pin_view;
        struct packed {
            logic [`ATM_IN_W-4:0] upper;
            logic [2:0]           code;     // bit 0 is the yes flag
        } menu_view;
    } atm_entry_u;

    typedef struct packed {
        disp_msg_e              disp;
        logic                   valid;
        logic [`ATM_OUT_W-1:0]  data;
    } svc_out_t;

endpackage

/* include/atm_settings.svh */
`ifndef ATM_SETTINGS_SVH
`define ATM_SETTINGS_SVH

// bus widths
`define ATM_IN_W    32
`define ATM_OUT_W   32
`define ATM_DISP_W  5

// account record
`define ATM_BAL_W   16
`define ATM_PIN_W   14
`define ATM_CASH_W  10

`define ATM_INIT_BAL  50
`define ATM_INIT_PIN  2000

// cycles a timed state waits for input
`define ATM_DWELL   8

`endif
